/* design/core_pkg.sv */
// RV32I subset only: register and immediate ALU ops plus LW/SW, no branches, jumps or CSRs
`default_nettype none

package core_pkg;

  // Data and address width
  localparam int xlen_c = 32;

  // Only word access exists, funct3 for LW and SW
  localparam logic [2:0] f3_word_c = 3'b010;

  typedef logic [4:0] reg_idx_t;

  // Major opcodes of the subset, anything else decodes as a bubble
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_t;

  typedef enum logic [2:0] {
    F3_ADD = 3'b000,
    F3_SLT = 3'b010,
    F3_XOR = 3'b100,
    F3_OR  = 3'b110,
    F3_AND = 3'b111
  } funct3_t;

  // funct7 picks ADD or SUB
  typedef enum logic [6:0] {
    F7_BASE = 7'b0000000,
    F7_ALT  = 7'b0100000
  } funct7_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_type_t;

  // Store offset is split around rs2
  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
  } instr_u;

endpackage

`default_nettype wire

/* design/pipe_if.sv */
// Stage-to-stage buses; only fetch to decode has back-pressure, later stages never stall
`default_nettype none

interface fetch_dec_if import core_pkg::*; ();
  logic              valid;
  logic [xlen_c-1:0] pc;
  logic [xlen_c-1:0] instr;
  logic              ready;

  modport source (output valid, pc, instr, input ready);
  modport sink (input valid, pc, instr, output ready);
endinterface

interface dec_ex_if import core_pkg::*; ();
  logic              valid;
  logic [xlen_c-1:0] pc;
  alu_op_t           alu_op;
  logic [xlen_c-1:0] operand_a;
  logic [xlen_c-1:0] operand_b;
  logic [xlen_c-1:0] store_data;
  reg_idx_t          rd;
  logic              reg_write;
  logic              mem_read;
  logic              mem_write;

  modport source (output valid, pc, alu_op, operand_a, operand_b, store_data, rd,
                  reg_write, mem_read, mem_write);
  modport sink (input valid, pc, alu_op, operand_a, operand_b, store_data, rd,
                reg_write, mem_read, mem_write);
  // Hazard check view
  modport monitor (input valid, rd, reg_write);
endinterface

interface ex_mem_if import core_pkg::*; ();
  logic              valid;
  logic [xlen_c-1:0] pc;
  logic [xlen_c-1:0] result;
  logic [xlen_c-1:0] store_data;
  reg_idx_t          rd;
  logic              reg_write;
  logic              mem_read;
  logic              mem_write;

  modport source (output valid, pc, result, store_data, rd, reg_write, mem_read, mem_write);
  modport sink (input valid, pc, result, store_data, rd, reg_write, mem_read, mem_write);
  modport monitor (input valid, rd, reg_write);
endinterface

`default_nettype wire

/* design/fetch_stage.sv */
// IMEM_WORDS must be a power of two of at least 2; the load port only writes while rst is high
`default_nettype none

module fetch_stage import core_pkg::*; #(
  parameter int IMEM_WORDS = 64
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          imem_wr_en,
  input  logic [$clog2(IMEM_WORDS)-1:0] imem_wr_addr,
  input  logic [xlen_c-1:0]             imem_wr_data,
  fetch_dec_if.source                   fd
);

  localparam int imem_aw = $clog2(IMEM_WORDS);

  logic [xlen_c-1:0]  imem [IMEM_WORDS];
  logic [xlen_c-1:0]  pc;
  logic [imem_aw-1:0] pc_idx;
  logic               fetch_en;

  // PC wraps inside the array
  assign pc_idx = pc[imem_aw+1:2];

  // Refill when the fetch register is empty or being taken by decode
  assign fetch_en = !fd.valid || fd.ready;

  // Program load
  always_ff @(posedge clk)
  begin
    if (rst && imem_wr_en)
    begin
      imem[imem_wr_addr] <= imem_wr_data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc       <= '0;
      fd.valid <= 1'b0;
    end
    else if (fetch_en)
    begin
      pc       <= pc + xlen_c'(4);
      fd.valid <= 1'b1;
    end
  end

  // Fetch register payload
  always_ff @(posedge clk)
  begin
    if (fetch_en)
    begin
      fd.pc    <= pc;
      fd.instr <= imem[pc_idx];
    end
  end

endmodule

`default_nettype wire

/* design/register_file.sv */
// x0 reads as zero; a write in the same cycle is seen by the combinational reads
`default_nettype none

module register_file import core_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  reg_idx_t          rs1,
  input  reg_idx_t          rs2,
  output logic [xlen_c-1:0] rs1_data,
  output logic [xlen_c-1:0] rs2_data,
  input  logic              wr_en,
  input  reg_idx_t          wr_idx,
  input  logic [xlen_c-1:0] wr_data
);

  logic [xlen_c-1:0] regs [32];

  function automatic logic [xlen_c-1:0] read_port(reg_idx_t idx);
    if (idx == '0)
      return '0;
    else if (wr_en && wr_idx == idx)
      return wr_data;
    else
      return regs[idx];
  endfunction

  always_comb
  begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    // Writes to x0 are dropped
    else if (wr_en && wr_idx != '0)
    begin
      regs[wr_idx] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* design/decode_stage.sv */
// No forwarding: RAW hazards stall until the producer is in writeback; unsupported words become bubbles
`default_nettype none

module decode_stage import core_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  fetch_dec_if.sink         fd,
  dec_ex_if.source          de,
  dec_ex_if.monitor         de_mon,
  ex_mem_if.monitor         em_mon,
  input  logic              wb_valid,
  input  reg_idx_t          wb_rd,
  input  logic [xlen_c-1:0] wb_data
);

  instr_u            ins;
  logic [xlen_c-1:0] rs1_data;
  logic [xlen_c-1:0] rs2_data;
  logic [xlen_c-1:0] imm;
  alu_op_t           alu_op;
  logic              supported;
  logic              use_rs2;
  logic              reg_write;
  logic              mem_read;
  logic              mem_write;
  logic              hazard;
  logic              accept;

  // True when a valid writer ahead still owes src to the register file
  function automatic logic pending(logic valid, logic wr, reg_idx_t rd, reg_idx_t src);
    return valid && wr && rd != '0 && rd == src;
  endfunction

  assign ins = fd.instr;

  register_file u_register_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (ins.r.rs1),
    .rs2      (ins.r.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wb_valid),
    .wr_idx   (wb_rd),
    .wr_data  (wb_data)
  );

  always_comb
  begin
    supported = 1'b0;
    use_rs2   = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    alu_op    = ALU_ADD;
    imm       = {{(xlen_c-12){ins.i.imm[11]}}, ins.i.imm};
    case (ins.r.opcode)
      OP:
      begin
        supported = 1'b1;
        use_rs2   = 1'b1;
        reg_write = 1'b1;
        case ({ins.r.funct7, ins.r.funct3})
          {F7_BASE, F3_ADD}: alu_op = ALU_ADD;
          {F7_ALT, F3_ADD}:  alu_op = ALU_SUB;
          {F7_BASE, F3_SLT}: alu_op = ALU_SLT;
          {F7_BASE, F3_XOR}: alu_op = ALU_XOR;
          {F7_BASE, F3_OR}:  alu_op = ALU_OR;
          {F7_BASE, F3_AND}: alu_op = ALU_AND;
          default:           supported = 1'b0;
        endcase
      end
      OP_IMM:
      begin
        supported = 1'b1;
        reg_write = 1'b1;
        case (ins.i.funct3)
          F3_ADD:  alu_op = ALU_ADD;
          F3_XOR:  alu_op = ALU_XOR;
          F3_OR:   alu_op = ALU_OR;
          F3_AND:  alu_op = ALU_AND;
          // Shifts and SLTI are outside the subset
          default: supported = 1'b0;
        endcase
      end
      LOAD:
      begin
        supported = ins.i.funct3 == f3_word_c;
        reg_write = 1'b1;
        mem_read  = 1'b1;
      end
      STORE:
      begin
        supported = ins.s.funct3 == f3_word_c;
        use_rs2   = 1'b1;
        mem_write = 1'b1;
        imm       = {{(xlen_c-12){ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
      end
      default:
      begin
        supported = 1'b0;
      end
    endcase
  end

  // Writeback is covered by the register file bypass
  assign hazard = fd.valid && supported &&
                  (pending(de_mon.valid, de_mon.reg_write, de_mon.rd, ins.r.rs1) ||
                   pending(em_mon.valid, em_mon.reg_write, em_mon.rd, ins.r.rs1) ||
                   (use_rs2 &&
                    (pending(de_mon.valid, de_mon.reg_write, de_mon.rd, ins.r.rs2) ||
                     pending(em_mon.valid, em_mon.reg_write, em_mon.rd, ins.r.rs2))));

  assign fd.ready = !hazard;
  assign accept   = fd.valid && fd.ready && supported;

  // Control half of the decode/execute register, cleared on a bubble
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      de.valid     <= 1'b0;
      de.reg_write <= 1'b0;
      de.mem_read  <= 1'b0;
      de.mem_write <= 1'b0;
    end
    else
    begin
      de.valid     <= accept;
      de.reg_write <= accept && reg_write;
      de.mem_read  <= accept && mem_read;
      de.mem_write <= accept && mem_write;
    end
  end

  always_ff @(posedge clk)
  begin
    de.pc         <= fd.pc;
    de.alu_op     <= alu_op;
    de.operand_a  <= rs1_data;
    de.operand_b  <= (ins.r.opcode == OP) ? rs2_data : imm;
    de.store_data <= rs2_data;
    // Stores retire with rd zero
    de.rd         <= reg_write ? ins.r.rd : '0;
  end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
// Single-cycle ALU, never stalls; loads and stores use the adder for base plus offset
`default_nettype none

module execute_stage import core_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  dec_ex_if.sink   de,
  ex_mem_if.source em
);

  logic [xlen_c-1:0] alu_result;
  logic              less;

  // SLT compares as signed
  assign less = $signed(de.operand_a) < $signed(de.operand_b);

  always_comb
  begin
    case (de.alu_op)
      ALU_ADD: alu_result = de.operand_a + de.operand_b;
      ALU_SUB: alu_result = de.operand_a - de.operand_b;
      ALU_AND: alu_result = de.operand_a & de.operand_b;
      ALU_OR:  alu_result = de.operand_a | de.operand_b;
      ALU_XOR: alu_result = de.operand_a ^ de.operand_b;
      ALU_SLT: alu_result = {{(xlen_c-1){1'b0}}, less};
      default: alu_result = de.operand_a + de.operand_b;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      em.valid     <= 1'b0;
      em.reg_write <= 1'b0;
      em.mem_read  <= 1'b0;
      em.mem_write <= 1'b0;
    end
    else
    begin
      em.valid     <= de.valid;
      em.reg_write <= de.reg_write;
      em.mem_read  <= de.mem_read;
      em.mem_write <= de.mem_write;
    end
  end

  // Result and pass-through payload
  always_ff @(posedge clk)
  begin
    em.pc         <= de.pc;
    em.result     <= alu_result;
    em.store_data <= de.store_data;
    em.rd         <= de.rd;
  end

endmodule

`default_nettype wire

/* design/memory_stage.sv */
// DMEM_WORDS must be a power of two of at least 2; word access only, address bits 1:0 ignored
`default_nettype none

module memory_stage import core_pkg::*; #(
  parameter int DMEM_WORDS = 64
) (
  input  logic              clk,
  input  logic              rst,
  ex_mem_if.sink            em,
  output logic              wb_valid,
  output logic [xlen_c-1:0] wb_pc,
  output reg_idx_t          wb_rd,
  output logic [xlen_c-1:0] wb_data
);

  localparam int dmem_aw = $clog2(DMEM_WORDS);

  logic [xlen_c-1:0]  dmem [DMEM_WORDS];
  logic [dmem_aw-1:0] word_idx;
  logic [xlen_c-1:0]  load_data;

  assign word_idx  = em.result[dmem_aw+1:2];
  assign load_data = dmem[word_idx];

  // Store lands at the end of the memory cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < DMEM_WORDS; i++)
        dmem[i] <= '0;
    end
    else if (em.valid && em.mem_write)
    begin
      dmem[word_idx] <= em.store_data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      wb_valid <= 1'b0;
    else
      wb_valid <= em.valid;
  end

  // Stores report the stored word as retire data
  always_ff @(posedge clk)
  begin
    wb_pc <= em.pc;
    wb_rd <= em.rd;
    if (em.mem_write)
      wb_data <= em.store_data;
    else if (em.mem_read)
      wb_data <= load_data;
    else
      wb_data <= em.result;
  end

endmodule

`default_nettype wire

/* design/rv_core.sv */
// Four-stage RV32I subset core; load the program while rst is high, memory depths powers of two
`default_nettype none

module rv_core import core_pkg::*; #(
  parameter int IMEM_WORDS = 64,
  parameter int DMEM_WORDS = 64
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          imem_wr_en,
  input  logic [$clog2(IMEM_WORDS)-1:0] imem_wr_addr,
  input  logic [xlen_c-1:0]             imem_wr_data,
  output logic                          retire_valid,
  output logic [xlen_c-1:0]             retire_pc,
  output reg_idx_t                      retire_rd,
  output logic [xlen_c-1:0]             retire_data
);

  fetch_dec_if u_fd_if ();
  dec_ex_if    u_de_if ();
  ex_mem_if    u_em_if ();

  fetch_stage #(
    .IMEM_WORDS (IMEM_WORDS)
  ) u_fetch_stage (
    .clk          (clk),
    .rst          (rst),
    .imem_wr_en   (imem_wr_en),
    .imem_wr_addr (imem_wr_addr),
    .imem_wr_data (imem_wr_data),
    .fd           (u_fd_if)
  );

  // Writeback feeds the register file through the retire ports
  decode_stage u_decode_stage (
    .clk      (clk),
    .rst      (rst),
    .fd       (u_fd_if),
    .de       (u_de_if),
    .de_mon   (u_de_if),
    .em_mon   (u_em_if),
    .wb_valid (retire_valid),
    .wb_rd    (retire_rd),
    .wb_data  (retire_data)
  );

  execute_stage u_execute_stage (
    .clk (clk),
    .rst (rst),
    .de  (u_de_if),
    .em  (u_em_if)
  );

  memory_stage #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_memory_stage (
    .clk      (clk),
    .rst      (rst),
    .em       (u_em_if),
    .wb_valid (retire_valid),
    .wb_pc    (retire_pc),
    .wb_rd    (retire_rd),
    .wb_data  (retire_data)
  );

endmodule

`default_nettype wire

/* verif/core_tb.sv */
// Runs each program from a fresh reset; assumes 64-word memories and the default core parameters
`default_nettype none

module core_tb import core_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int imem_words_c = 64;
  localparam int dmem_words_c = 64;

  // Instruction kinds used by the test program
  localparam int K_ADD  = 0;
  localparam int K_SUB  = 1;
  localparam int K_AND  = 2;
  localparam int K_OR   = 3;
  localparam int K_XOR  = 4;
  localparam int K_SLT  = 5;
  localparam int K_ADDI = 6;
  localparam int K_ANDI = 7;
  localparam int K_ORI  = 8;
  localparam int K_XORI = 9;
  localparam int K_LW   = 10;
  localparam int K_SW   = 11;
  localparam int K_BAD  = 12;

  typedef struct {
    int kind;
    int rd;
    int rs1;
    int rs2;
    int imm;
  } op_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] data;
  } retire_t;

  logic        clk;
  logic        rst;
  logic        imem_wr_en;
  logic [5:0]  imem_wr_addr;
  logic [31:0] imem_wr_data;
  logic        retire_valid;
  logic [31:0] retire_pc;
  reg_idx_t    retire_rd;
  logic [31:0] retire_data;

  op_t         prog[$];
  retire_t     exp_q[$];
  logic        head_ok = 1'b0;
  logic [31:0] head_pc;
  logic [4:0]  head_rd;
  logic [31:0] head_data;
  logic        prev_rst = 1'b0;
  int          retired;
  int          errors;
  int          tests_run;
  int          total_retired;

  rv_core #(
    .IMEM_WORDS (imem_words_c),
    .DMEM_WORDS (dmem_words_c)
  ) u_rv_core (
    .clk          (clk),
    .rst          (rst),
    .imem_wr_en   (imem_wr_en),
    .imem_wr_addr (imem_wr_addr),
    .imem_wr_data (imem_wr_data),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic void refresh_head();
    head_ok = exp_q.size() > 0;
    if (head_ok)
    begin
      head_pc   = exp_q[0].pc;
      head_rd   = exp_q[0].rd;
      head_data = exp_q[0].data;
    end
  endfunction

  always @(posedge clk)
  begin
    prev_rst <= rst;
    if (!rst && retire_valid)
    begin
      retired++;
      if (exp_q.size() > 0)
        exp_q.delete(0);
      refresh_head();
    end
  end

  // Nothing retires in reset or in the first cycle after it
  assert property (@(posedge clk) prev_rst |-> !retire_valid)
  else
  begin
    $display("ERROR %0t: retire_valid high during or right after reset", $time);
    errors++;
  end

  // Every retirement matches the head of the model queue
  assert property (@(posedge clk) disable iff (rst)
    retire_valid |-> head_ok && retire_pc == head_pc && retire_rd == head_rd &&
                     retire_data == head_data)
  else
  begin
    if (!$sampled(head_ok))
      $display("ERROR %0t: retire at pc %h that the model does not expect",
               $time, $sampled(retire_pc));
    else
      $display("ERROR %0t: retire pc %h rd %0d data %h, expected pc %h rd %0d data %h",
               $time, $sampled(retire_pc), $sampled(retire_rd), $sampled(retire_data),
               $sampled(head_pc), $sampled(head_rd), $sampled(head_data));
    errors++;
  end

  function automatic void add_op(int kind, int rd, int rs1, int rs2, int imm);
    prog.push_back('{kind, rd, rs1, rs2, imm});
  endfunction

  function automatic int rnd_reg();
    return 1 + int'($urandom % 8);
  endfunction

  function automatic logic [31:0] encode(op_t op);
    instr_u     w;
    logic [2:0] f3;
    w = '0;
    case (op.kind)
      K_ADD, K_SUB, K_ADDI: f3 = F3_ADD;
      K_SLT:                f3 = F3_SLT;
      K_XOR, K_XORI:        f3 = F3_XOR;
      K_OR, K_ORI:          f3 = F3_OR;
      K_AND, K_ANDI:        f3 = F3_AND;
      default:              f3 = f3_word_c;
    endcase
    if (op.kind <= K_SLT)
    begin
      w.r.opcode = OP;
      w.r.funct7 = (op.kind == K_SUB) ? F7_ALT : F7_BASE;
      w.r.funct3 = f3;
      w.r.rd     = 5'(op.rd);
      w.r.rs1    = 5'(op.rs1);
      w.r.rs2    = 5'(op.rs2);
    end
    else if (op.kind <= K_LW)
    begin
      w.i.opcode = (op.kind == K_LW) ? LOAD : OP_IMM;
      w.i.funct3 = f3;
      w.i.rd     = 5'(op.rd);
      w.i.rs1    = 5'(op.rs1);
      w.i.imm    = 12'(op.imm);
    end
    else if (op.kind == K_SW)
    begin
      w.s.opcode = STORE;
      w.s.funct3 = f3;
      w.s.rs1    = 5'(op.rs1);
      w.s.rs2    = 5'(op.rs2);
      {w.s.imm_hi, w.s.imm_lo} = 12'(op.imm);
    end
    else if (op.rd != 0)
    begin
      // LUI lies outside the subset
      w = {20'(op.imm), 5'(op.rd), 7'b0110111};
    end
    return w;
  endfunction

  // In-order reference model with one queue entry per retiring instruction
  function automatic void model_program();
    logic [31:0] regs [32];
    logic [31:0] mem [dmem_words_c];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] res;
    logic [11:0] imm12;
    exp_q.delete();
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
    for (int i = 0; i < dmem_words_c; i++)
      mem[i] = '0;
    foreach (prog[i])
    begin
      a     = regs[prog[i].rs1];
      b     = regs[prog[i].rs2];
      imm12 = 12'(prog[i].imm);
      imm   = {{20{imm12[11]}}, imm12};
      addr  = a + imm;
      case (prog[i].kind)
        K_ADD:   res = a + b;
        K_SUB:   res = a - b;
        K_AND:   res = a & b;
        K_OR:    res = a | b;
        K_XOR:   res = a ^ b;
        K_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        K_ADDI:  res = a + imm;
        K_ANDI:  res = a & imm;
        K_ORI:   res = a | imm;
        K_XORI:  res = a ^ imm;
        K_LW:    res = mem[addr[7:2]];
        K_SW:    res = b;
        default: continue;
      endcase
      if (prog[i].kind == K_SW)
        mem[addr[7:2]] = b;
      else if (prog[i].rd != 0)
        regs[prog[i].rd] = res;
      exp_q.push_back('{32'(4 * i), (prog[i].kind == K_SW) ? 5'd0 : 5'(prog[i].rd), res});
    end
    refresh_head();
  endfunction

  task automatic run_program(string name);
    int n_exp;
    int waited;
    int err_before;
    err_before = errors;
    @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < imem_words_c; i++)
    begin
      @(posedge clk);
      imem_wr_en   <= 1'b1;
      imem_wr_addr <= 6'(i);
      imem_wr_data <= (i < prog.size()) ? encode(prog[i]) : '0;
    end
    @(posedge clk);
    imem_wr_en <= 1'b0;
    retired = 0;
    model_program();
    n_exp = exp_q.size();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    waited = 0;
    while (retired < n_exp && waited < 500)
    begin
      @(negedge clk);
      waited++;
    end
    if (retired < n_exp)
    begin
      $display("%s: core stopped retiring after %0d of %0d instructions", name, retired, n_exp);
      errors++;
    end
    // Drain so that any extra retirement trips the check
    repeat (12) @(posedge clk);
    $display("%s: %0d retired, %0d errors", name, retired, errors - err_before);
    total_retired += retired;
    tests_run++;
  endtask

  initial
  begin
    int kind;
    void'($urandom(32'h8719_063e));
    rst          = 1'b1;
    imem_wr_en   = 1'b0;
    imem_wr_addr = '0;
    imem_wr_data = '0;
    errors       = 0;
    tests_run    = 0;
    retired      = 0;
    total_retired = 0;

    prog.delete();
    run_program("reset and zero program");

    prog.delete();
    add_op(K_ADDI, 1, 0, 0, 100);
    add_op(K_ADDI, 2, 0, 0, -7);
    add_op(K_ADDI, 3, 0, 0, -2048);
    add_op(K_ADDI, 4, 0, 0, 2047);
    add_op(K_ADD, 5, 1, 2, 0);
    add_op(K_SUB, 6, 2, 1, 0);
    add_op(K_AND, 7, 1, 2, 0);
    add_op(K_OR, 8, 3, 4, 0);
    add_op(K_XOR, 9, 2, 4, 0);
    add_op(K_SLT, 10, 2, 1, 0);
    add_op(K_SLT, 11, 1, 2, 0);
    add_op(K_ANDI, 12, 2, 0, 'h0f0);
    add_op(K_ORI, 13, 1, 0, -256);
    add_op(K_XORI, 14, 4, 0, -1);
    run_program("alu operations");

    prog.delete();
    add_op(K_ADDI, 1, 0, 0, 3);
    add_op(K_ADDI, 2, 0, 0, -5);
    for (int i = 0; i < 5; i++)
    begin
      add_op(K_ADD, 1, 1, 1, 0);
      add_op(K_XOR, 2, 1, 2, 0);
      add_op(K_SLT, 3, 2, 1, 0);
      add_op(K_SUB, 1, 1, 3, 0);
    end
    add_op(K_ADDI, 4, 1, 0, -1);
    add_op(K_OR, 5, 4, 4, 0);
    run_program("dependent chains");

    prog.delete();
    add_op(K_ADDI, 1, 0, 0, 'h55);
    add_op(K_ADDI, 2, 0, 0, -3);
    add_op(K_SW, 0, 0, 1, 8);
    add_op(K_SW, 0, 0, 2, 12);
    add_op(K_LW, 3, 0, 0, 8);
    add_op(K_LW, 4, 0, 0, 12);
    add_op(K_LW, 5, 0, 0, 16);
    add_op(K_SW, 0, 0, 2, 8);
    add_op(K_LW, 6, 0, 0, 8);
    add_op(K_ADDI, 7, 0, 0, 20);
    add_op(K_SW, 0, 7, 1, -4);
    add_op(K_LW, 8, 0, 0, 16);
    run_program("store and load");

    prog.delete();
    add_op(K_ADDI, 0, 0, 0, 5);
    add_op(K_ADD, 1, 0, 0, 0);
    add_op(K_BAD, 3, 0, 0, 'h12345);
    add_op(K_ADDI, 2, 0, 0, 9);
    add_op(K_BAD, 0, 0, 0, 0);
    add_op(K_ADD, 3, 0, 2, 0);
    add_op(K_BAD, 2, 0, 0, 'hfffff);
    add_op(K_OR, 4, 0, 3, 0);
    run_program("x0 and unsupported words");

    prog.delete();
    for (int i = 0; i < 40; i++)
    begin
      kind = int'($urandom % 12);
      if (kind == K_LW || kind == K_SW)
        add_op(kind, rnd_reg(), 0, rnd_reg(), 4 * int'($urandom % 8));
      else
        add_op(kind, rnd_reg(), rnd_reg(), rnd_reg(), int'($urandom % 4096) - 2048);
    end
    run_program("random program");

    $display("tests %0d, retired %0d, errors %0d", tests_run, total_retired, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
design/core_pkg.sv
design/pipe_if.sv
design/fetch_stage.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/rv_core.sv
verif/core_tb.sv
